/* bridge_pkg.sv */
package bridge_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int STRB_W = DATA_W / 8;

    // axi id tags
    // instruction reads on id 0, all data traffic on id 1
    localparam logic [ID_W-1:0] ID_INST = 'd0;
    localparam logic [ID_W-1:0] ID_DATA = 'd1;

    // beats per cache line fetch
    localparam int LINE_BEATS = 4;

    // ram depth in words, indexed by addr[9:2]
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    // instruction fetch type from the icache
    typedef enum logic [2:0] {
        FETCH_WORD = 3'd0,
        FETCH_LINE = 3'd4
    } fetch_type_e;

    // read address fsm, one-hot
    typedef enum logic [2:0] {
        AR_IDLE = 3'b001,
        AR_DATA = 3'b010,
        AR_INST = 3'b100
    } ar_state_e;

    // write address and data fsm, one-hot
    typedef enum logic [2:0] {
        AW_IDLE = 3'b001,
        AW_ADDR = 3'b010,
        AW_DATA = 3'b100
    } aw_state_e;

    // write response fsm
    typedef enum logic {
        B_IDLE = 1'b0,
        B_DONE = 1'b1
    } b_state_e;

    // axi channel payloads
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

endpackage

/* ar_channel_ctrl.sv */
`timescale 1ns/1ns

module ar_channel_ctrl import bridge_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              inst_req,
    input  logic [ADDR_W-1:0] inst_addr,
    input  fetch_type_e       inst_type,
    input  logic              data_req,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic              data_rd_take,
    input  logic              inst_take,
    input  logic              arready,
    output axi_ar_t           ar,
    output logic              arvalid,
    output logic              ar_idle
);

    ar_state_e         state;
    ar_state_e         state_nxt;
    logic [ADDR_W-1:0] inst_addr_q;
    fetch_type_e       inst_type_q;
    logic              inst_pend;
    logic [ADDR_W-1:0] data_addr_q;
    logic              data_go;
    logic              inst_go;

    // take windows qualified by the requests themselves
    assign data_go = data_req & data_rd_take;
    assign inst_go = inst_req & inst_take;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= AR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            AR_IDLE: begin
                // data read wins a collision
                if (data_go) begin
                    state_nxt = AR_DATA;
                end else if (inst_go) begin
                    state_nxt = AR_INST;
                end
            end
            AR_DATA: begin
                // chain a captured fetch straight after
                if (arready) begin
                    state_nxt = inst_pend ? AR_INST : AR_IDLE;
                end
            end
            AR_INST: begin
                if (arready) begin
                    state_nxt = AR_IDLE;
                end
            end
            default: state_nxt = AR_IDLE;
        endcase
    end

    // pending fetch flag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_pend <= 1'b0;
        end else if (state == AR_IDLE && inst_go) begin
            inst_pend <= 1'b1;
        end else if (state == AR_INST && arready) begin
            inst_pend <= 1'b0;
        end
    end

    // request capture, payload only
    always_ff @(posedge clk) begin
        if (state == AR_IDLE && inst_go) begin
            inst_addr_q <= inst_addr;
            inst_type_q <= inst_type;
        end
        if (state == AR_IDLE && data_go) begin
            data_addr_q <= data_addr;
        end
    end

    assign arvalid = (state == AR_DATA) || (state == AR_INST);
    assign ar_idle = (state == AR_IDLE);

    // data reads are always one beat
    assign ar.id   = (state == AR_DATA) ? ID_DATA : ID_INST;
    assign ar.addr = (state == AR_DATA) ? data_addr_q : inst_addr_q;
    assign ar.len  = (state != AR_DATA && inst_type_q == FETCH_LINE) ?
                     8'(LINE_BEATS - 1) : 8'd0;

endmodule

/* aw_channel_ctrl.sv */
`timescale 1ns/1ns

module aw_channel_ctrl import bridge_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              wr_take,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    input  logic [STRB_W-1:0] data_wstrb,
    input  logic              awready,
    input  logic              wready,
    input  logic              bvalid,
    output axi_aw_t           aw,
    output logic              awvalid,
    output axi_w_t            w,
    output logic              wvalid,
    output logic              bready,
    output logic              aw_idle,
    output logic              wr_done
);

    aw_state_e aw_state;
    aw_state_e aw_state_nxt;
    b_state_e  b_state;
    b_state_e  b_state_nxt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_state <= AW_IDLE;
            b_state  <= B_IDLE;
        end else begin
            aw_state <= aw_state_nxt;
            b_state  <= b_state_nxt;
        end
    end

    // address phase then data phase
    always_comb begin
        aw_state_nxt = aw_state;
        case (aw_state)
            AW_IDLE: begin
                if (wr_take) begin
                    aw_state_nxt = AW_ADDR;
                end
            end
            AW_ADDR: begin
                if (awready) begin
                    aw_state_nxt = AW_DATA;
                end
            end
            AW_DATA: begin
                if (wready) begin
                    aw_state_nxt = AW_IDLE;
                end
            end
            default: aw_state_nxt = AW_IDLE;
        endcase
    end

    // response taken in idle, done pulse one cycle later
    always_comb begin
        b_state_nxt = b_state;
        case (b_state)
            B_IDLE: begin
                if (bvalid) begin
                    b_state_nxt = B_DONE;
                end
            end
            default: b_state_nxt = B_IDLE;
        endcase
    end

    // write payload held until the w handshake
    always_ff @(posedge clk) begin
        if (aw_state == AW_IDLE && wr_take) begin
            aw.addr <= data_addr;
            w.data  <= data_wdata;
            w.strb  <= data_wstrb;
        end
    end

    assign awvalid = (aw_state == AW_ADDR);
    assign wvalid  = (aw_state == AW_DATA);
    assign aw_idle = (aw_state == AW_IDLE);
    assign bready  = (b_state == B_IDLE);
    assign wr_done = (b_state == B_DONE);

endmodule

/* sram_axi_bridge.sv */
`timescale 1ns/1ns

module sram_axi_bridge import bridge_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    // instruction side
    input  logic              inst_req,
    input  logic [ADDR_W-1:0] inst_addr,
    input  fetch_type_e       inst_type,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,
    output logic [DATA_W-1:0] inst_rdata,
    output logic              inst_last,
    // data side
    input  logic              data_req,
    input  logic              data_wr,
    input  logic [STRB_W-1:0] data_wstrb,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic              data_addr_ok,
    output logic              data_data_ok,
    output logic [DATA_W-1:0] data_rdata,
    // axi master
    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output axi_aw_t           aw,
    output logic              awvalid,
    input  logic              awready,
    output axi_w_t            w,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready
);

    logic ar_idle;
    logic aw_idle;
    logic addr_ok;
    logic wr_done;
    logic data_rd_take;
    logic wr_take;

    // accept only with both address sides idle
    assign addr_ok      = ar_idle & aw_idle;
    assign inst_addr_ok = addr_ok;
    assign data_addr_ok = addr_ok;

    // read windows, the ar side checks the req lines
    assign data_rd_take = addr_ok & ~data_wr;
    assign wr_take      = addr_ok & data_req & data_wr;

    ar_channel_ctrl i_ar_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_type    (inst_type),
        .data_req     (data_req),
        .data_addr    (data_addr),
        .data_rd_take (data_rd_take),
        .inst_take    (addr_ok),
        .arready      (arready),
        .ar           (ar),
        .arvalid      (arvalid),
        .ar_idle      (ar_idle)
    );

    aw_channel_ctrl i_aw_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .wr_take    (wr_take),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_wstrb (data_wstrb),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .aw         (aw),
        .awvalid    (awvalid),
        .w          (w),
        .wvalid     (wvalid),
        .bready     (bready),
        .aw_idle    (aw_idle),
        .wr_done    (wr_done)
    );

    // r beats routed by id, rready tied high
    assign inst_data_ok = rvalid && (r.id == ID_INST);
    assign inst_rdata   = r.data;
    assign inst_last    = r.last;

    // data side sees read beats and write completions
    assign data_data_ok = (rvalid && (r.id == ID_DATA)) || wr_done;
    assign data_rdata   = r.data;

endmodule

/* axi_ram.sv */
`timescale 1ns/1ns

module axi_ram import bridge_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output logic    bvalid,
    input  logic    bready
);

    logic [DATA_W-1:0]    mem [RAM_WORDS];

    // read burst state
    logic                 rd_active;
    logic [RAM_IDX_W-1:0] rd_idx;
    logic [7:0]           rd_cnt;
    logic [7:0]           rd_len;
    logic [ID_W-1:0]      rd_id;
    logic                 ar_hs;
    logic                 rd_last;

    // write state
    logic                 aw_full;
    logic [RAM_IDX_W-1:0] wr_idx;
    logic                 aw_hs;
    logic                 w_hs;

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // no new burst until the last beat is issued
    assign arready = ~rd_active;
    assign ar_hs   = arvalid & arready;
    assign rd_last = (rd_cnt == rd_len);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_active <= 1'b0;
        end else if (ar_hs) begin
            rd_active <= 1'b1;
        end else if (rd_active && rd_last) begin
            rd_active <= 1'b0;
        end
    end

    // burst counters, incrementing word address
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_idx <= ar.addr[RAM_IDX_W+1:2];
            rd_len <= ar.len;
            rd_id  <= ar.id;
            rd_cnt <= 8'd0;
        end else if (rd_active) begin
            rd_idx <= rd_idx + 1'b1;
            rd_cnt <= rd_cnt + 8'd1;
        end
    end

    // access stage
    // array read one cycle after capture, beat out the cycle after
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= rd_active;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_active) begin
            r.id   <= rd_id;
            r.data <= mem[rd_idx];
            r.last <= rd_last;
        end
    end

    // one write in flight, address then data then response
    assign awready = ~aw_full & ~bvalid;
    assign wready  = aw_full & ~bvalid;
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_full <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_full <= 1'b1;
            end else if (w_hs) begin
                aw_full <= 1'b0;
            end
            // held until the master takes it
            if (w_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_idx <= aw.addr[RAM_IDX_W+1:2];
        end
    end

    // byte merge under strobes
    always_ff @(posedge clk) begin
        if (w_hs) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (w.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= w.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top import bridge_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    // instruction port
    input  logic              inst_req,
    input  logic [ADDR_W-1:0] inst_addr,
    input  fetch_type_e       inst_type,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,
    output logic [DATA_W-1:0] inst_rdata,
    output logic              inst_last,
    // data port
    input  logic              data_req,
    input  logic              data_wr,
    input  logic [STRB_W-1:0] data_wstrb,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic              data_addr_ok,
    output logic              data_data_ok,
    output logic [DATA_W-1:0] data_rdata
);

    // bridge to ram channels
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    logic    bvalid;
    logic    bready;

    sram_axi_bridge i_bridge (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_type    (inst_type),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .inst_last    (inst_last),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    axi_ram i_ram (
        .clk     (clk),
        .resetn  (resetn),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys import bridge_pkg::*; ();

    // cycles allowed for any single wait
    localparam int WAIT_LIMIT = 100;
    localparam int RANDOM_OPS = 300;

    logic              clk;
    logic              resetn;
    logic              inst_req;
    logic [ADDR_W-1:0] inst_addr;
    fetch_type_e       inst_type;
    logic              inst_addr_ok;
    logic              inst_data_ok;
    logic [DATA_W-1:0] inst_rdata;
    logic              inst_last;
    logic              data_req;
    logic              data_wr;
    logic [STRB_W-1:0] data_wstrb;
    logic [ADDR_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
    logic              data_addr_ok;
    logic              data_data_ok;
    logic [DATA_W-1:0] data_rdata;

    // reference memory and expected response queues in arrival order
    logic [DATA_W-1:0] ref_mem [RAM_WORDS];
    logic [DATA_W-1:0] exp_inst_word [$];
    logic              exp_inst_last [$];
    logic [DATA_W-1:0] exp_data_word [$];
    logic              exp_data_wr [$];
    int                inst_seen;
    int                inst_issued;
    int                data_seen;
    int                data_issued;
    int                err_cnt;
    logic [31:0]       rng;

    mem_subsys_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_type    (inst_type),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .inst_last    (inst_last),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected word from the ram mirror at addr[9:2]
    function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        return ref_mem[addr[9:2]];
    endfunction

    // byte lanes with strobe set take the new data
    task automatic merge_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [STRB_W-1:0] strb);
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                ref_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // called on a falling edge with req already driven
    task automatic wait_addr_ok();
        int n;
        n = 0;
        while (!(inst_addr_ok && data_addr_ok)) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("timeout waiting for addr_ok");
        end
    endtask

    // counters move on falling edges and are polled on rising ones
    task automatic wait_responses(input bit with_inst);
        int n;
        n = 0;
        while (data_seen != data_issued || (with_inst && inst_seen != inst_issued)) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) abort_run("timeout waiting for data_ok responses");
        end
    endtask

    // line fetch covers addr through addr+12 with last on the final beat
    task automatic expect_fetch(input logic [ADDR_W-1:0] addr, input fetch_type_e kind);
        int beats;
        beats = (kind == FETCH_LINE) ? LINE_BEATS : 1;
        for (int k = 0; k < beats; k++) begin
            exp_inst_word.push_back(ref_word(addr + 32'(4 * k)));
            exp_inst_last.push_back(k == beats - 1);
        end
        inst_issued += beats;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
        @(negedge clk);
        data_req   = 1'b1;
        data_wr    = 1'b1;
        data_addr  = addr;
        data_wdata = data;
        data_wstrb = strb;
        exp_data_wr.push_back(1'b1);
        exp_data_word.push_back('0);
        data_issued++;
        wait_addr_ok();
        merge_write(addr, data, strb);
        @(negedge clk);
        data_req = 1'b0;
        data_wr  = 1'b0;
        wait_responses(1'b1);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        @(negedge clk);
        data_req  = 1'b1;
        data_wr   = 1'b0;
        data_addr = addr;
        exp_data_wr.push_back(1'b0);
        exp_data_word.push_back(ref_word(addr));
        data_issued++;
        wait_addr_ok();
        @(negedge clk);
        data_req = 1'b0;
        wait_responses(1'b1);
    endtask

    task automatic fetch_inst(input logic [ADDR_W-1:0] addr, input fetch_type_e kind);
        @(negedge clk);
        inst_req  = 1'b1;
        inst_addr = addr;
        inst_type = kind;
        expect_fetch(addr, kind);
        wait_addr_ok();
        @(negedge clk);
        inst_req = 1'b0;
        wait_responses(1'b1);
    endtask

    // both ports in one cycle and the data read finishes first
    task automatic read_both(input logic [ADDR_W-1:0] iaddr, input fetch_type_e kind,
                             input logic [ADDR_W-1:0] daddr);
        int inst_before;
        inst_before = inst_seen;
        @(negedge clk);
        inst_req  = 1'b1;
        inst_addr = iaddr;
        inst_type = kind;
        data_req  = 1'b1;
        data_wr   = 1'b0;
        data_addr = daddr;
        expect_fetch(iaddr, kind);
        exp_data_wr.push_back(1'b0);
        exp_data_word.push_back(ref_word(daddr));
        data_issued++;
        wait_addr_ok();
        @(negedge clk);
        inst_req = 1'b0;
        data_req = 1'b0;
        wait_responses(1'b0);
        check_value("inst_beats_before_data_ok", 32'(inst_seen), 32'(inst_before));
        wait_responses(1'b1);
    endtask

    // outputs come from flops only and are stable at the falling edge
    always @(negedge clk) begin : response_check
        logic              wr;
        logic              last;
        logic [DATA_W-1:0] word;
        if (resetn) begin
            if (inst_data_ok) begin
                if (exp_inst_word.size() == 0) begin
                    abort_run("inst_data_ok seen with no fetch outstanding");
                end else begin
                    word = exp_inst_word.pop_front();
                    last = exp_inst_last.pop_front();
                    check_value("inst_rdata", inst_rdata, word);
                    check_value("inst_last", 32'(inst_last), 32'(last));
                    inst_seen++;
                end
            end
            if (data_data_ok) begin
                if (exp_data_wr.size() == 0) begin
                    abort_run("data_data_ok seen with no request outstanding");
                end else begin
                    wr   = exp_data_wr.pop_front();
                    word = exp_data_word.pop_front();
                    // write completions carry no data
                    if (!wr) begin
                        check_value("data_rdata", data_rdata, word);
                    end
                    data_seen++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [ADDR_W-1:0] addr;
        logic [2:0]        op;
        clk         = 1'b0;
        resetn      = 1'b0;
        inst_req    = 1'b0;
        inst_addr   = '0;
        inst_type   = FETCH_WORD;
        data_req    = 1'b0;
        data_wr     = 1'b0;
        data_wstrb  = '0;
        data_addr   = '0;
        data_wdata  = '0;
        inst_seen   = 0;
        inst_issued = 0;
        data_seen   = 0;
        data_issued = 0;
        err_cnt     = 0;
        rng         = 32'd58793;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // idle after reset
        @(negedge clk);
        check_value("inst_addr_ok", 32'(inst_addr_ok), 32'd1);
        check_value("data_addr_ok", 32'(data_addr_ok), 32'd1);
        repeat (5) begin
            @(negedge clk);
            check_value("inst_data_ok", 32'(inst_data_ok), 32'd0);
            check_value("data_data_ok", 32'(data_data_ok), 32'd0);
        end

        // full word write then read back at the same address
        write_word(32'h40, 32'hdeadbeef, 4'hf);
        read_word(32'h40);

        // partial strobes
        write_word(32'h44, 32'h11223344, 4'hf);
        write_word(32'h44, 32'haabbccdd, 4'b0101);
        write_word(32'h44, 32'h55667788, 4'b1000);
        read_word(32'h44);
        write_word(32'h40, 32'h000000ee, 4'b0001);
        read_word(32'h40);

        // line and word fetch over a known pattern
        for (int k = 0; k < LINE_BEATS; k++) begin
            write_word(32'h80 + 32'(4 * k), 32'hc0de0000 + 32'(k), 4'hf);
        end
        fetch_inst(32'h80, FETCH_LINE);
        fetch_inst(32'h84, FETCH_WORD);

        // colliding reads
        read_both(32'h80, FETCH_LINE, 32'h44);
        read_both(32'h88, FETCH_WORD, 32'h40);

        // random mix over sixteen words
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rng  = xorshift32(rng);
            op   = rng[2:0];
            addr = 32'h100 + {26'd0, rng[11:8], 2'b00};
            rng  = xorshift32(rng);
            case (op)
                3'd3: read_word(addr);
                3'd4: fetch_inst(addr, FETCH_WORD);
                3'd5: fetch_inst(addr, FETCH_LINE);
                3'd6: read_both(addr, rng[20] ? FETCH_LINE : FETCH_WORD,
                                32'h100 + {26'd0, rng[15:12], 2'b00});
                default: write_word(addr, rng, rng[23:20]);
            endcase
        end

        @(negedge clk);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("checks failed");
        end
    end

endmodule

/* vlog.f */
bridge_pkg.sv
ar_channel_ctrl.sv
aw_channel_ctrl.sv
sram_axi_bridge.sv
axi_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mem_subsys -f vlog.f -o sim_tb

# the fatal exit status is absorbed by tee, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
